//--- hw/cache_pkg.sv
package cache_pkg;

    // address split: tag | index | offset
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 7;
    localparam int OFFSET_W       = 5;

    localparam int WORDS_PER_LINE = 8;
    localparam int SETS           = 128;

    // valid bit sits above the tag
    localparam int TAGV_W         = TAG_W + 1;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef enum logic [1:0] {
        LOOKUP,
        REQUEST,
        REPLAY
    } miss_state_t;

endpackage

//--- hw/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram
    import cache_pkg::*;
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = SETS
) (
    input  logic             clk,
    input  logic             we,
    input  index_t           waddr,
    input  logic [WIDTH-1:0] wdata,
    input  index_t           raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps

module icache
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   inst_en,
    input  addr_t  pc,
    output logic   stall,
    output word_t  inst,
    output logic   rd_req,
    output addr_t  rd_addr,
    input  logic   ret_valid,
    input  line_t  ret_data
);

    localparam int WAYS = 2;

    miss_state_t state;
    miss_state_t state_next;

    // request accepted last cycle
    logic   req_valid;
    addr_t  req_addr;
    tag_t   req_tag;
    index_t req_index;
    logic [OFFSET_W-3:0] req_word;

    index_t ram_raddr;

    logic [TAGV_W-1:0] tagv_q [WAYS];
    word_t             bank_q [WAYS][WORDS_PER_LINE];

    // flop copy of the valid bits, cleared by reset
    logic [WAYS-1:0][SETS-1:0] valid_bits;
    logic [WAYS-1:0]           valid_q;

    logic [WAYS-1:0] hit_way;
    logic [WAYS-1:0] fill_we;
    logic [SETS-1:0] lru;
    logic            victim;
    logic            lookup;
    logic            hit;
    logic            miss;

    assign req_tag   = req_addr[OFFSET_W+INDEX_W +: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_addr[OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (!stall) begin
            req_valid <= inst_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_addr <= pc;
        end
    end

    // hold the set on the stored request while stalled
    assign ram_raddr = stall ? req_index : pc[OFFSET_W +: INDEX_W];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            sdp_ram #(
                .WIDTH ($bits(word_t)),
                .DEPTH (SETS)
            ) u_data (
                .clk   (clk),
                .we    (fill_we[w]),
                .waddr (req_index),
                .wdata (ret_data[b*32 +: 32]),
                .raddr (ram_raddr),
                .rdata (bank_q[w][b])
            );
        end

        sdp_ram #(
            .WIDTH (TAGV_W),
            .DEPTH (SETS)
        ) u_tagv (
            .clk   (clk),
            .we    (fill_we[w]),
            .waddr (req_index),
            .wdata ({1'b1, req_tag}),
            .raddr (ram_raddr),
            .rdata (tagv_q[w])
        );

        assign hit_way[w] = valid_q[w] && tagv_q[w][TAGV_W-1]
                            && (tagv_q[w][TAG_W-1:0] == req_tag);
        // refill goes to the way the lru bit names
        assign fill_we[w] = (state == REQUEST) && ret_valid && (victim == 1'(w));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (fill_we[w]) begin
                    valid_bits[w][req_index] <= 1'b1;
                end
            end
        end
    end

    // read alongside the tag RAMs
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            valid_q[w] <= valid_bits[w][ram_raddr];
        end
    end

    // compare only in LOOKUP, RAM outputs are stale otherwise
    assign lookup = req_valid && (state == LOOKUP);
    assign hit    = lookup && (|hit_way);
    assign miss   = lookup && !(|hit_way);

    assign stall   = miss || (state != LOOKUP);
    assign inst    = hit_way[1] ? bank_q[1][req_word] : bank_q[0][req_word];
    assign rd_req  = miss || (state == REQUEST);
    assign rd_addr = {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign victim = lru[req_index];

    // lru bit points at the way to replace next
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (hit) begin
            lru[req_index] <= hit_way[0];
        end else if (|fill_we) begin
            lru[req_index] <= !victim;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (miss) begin
                    state_next = REQUEST;
                end
            end
            REQUEST: begin
                if (ret_valid) begin
                    state_next = REPLAY;
                end
            end
            REPLAY: begin
                // one more read so the filled line reaches the outputs
                state_next = LOOKUP;
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- hw/line_mem.sv
`timescale 1ns/1ps

module line_mem
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_LINES   = 1024
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  ret_valid,
    output line_t ret_data,
    input  logic  load_en,
    input  addr_t load_addr,
    input  line_t load_data
);

    localparam int LINE_W = $clog2(MEM_LINES);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

    line_t mem [MEM_LINES];

    logic              busy;
    logic [CNT_W-1:0]  count;
    logic [LINE_W-1:0] line_q;
    logic              accept;
    logic              answer;

    // load_addr is a line number, wraps modulo MEM_LINES
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[LINE_W-1:0]] <= load_data;
        end
    end

    // rd_req is still high in the cycle of the answer
    assign accept = rd_req && !busy && !ret_valid;
    assign answer = busy && (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            count     <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= answer;
            if (answer) begin
                busy <= 1'b0;
            end else if (busy) begin
                count <= count - 1'b1;
            end else if (accept) begin
                busy  <= 1'b1;
                count <= CNT_W'(MEM_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            line_q <= rd_addr[OFFSET_W +: LINE_W];
        end
        if (answer) begin
            ret_data <= mem[line_q];
        end
    end

endmodule

//--- hw/fetch_cache_top.sv
`timescale 1ns/1ps

module fetch_cache_top
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_LINES   = 1024
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_en,
    input  addr_t pc,
    output logic  stall,
    output word_t inst,
    input  logic  load_en,
    input  addr_t load_addr,
    input  line_t load_data
);

    // line refill path
    logic  rd_req;
    addr_t rd_addr;
    logic  ret_valid;
    line_t ret_data;

    icache u_icache (
        .clk       (clk),
        .reset     (reset),
        .inst_en   (inst_en),
        .pc        (pc),
        .stall     (stall),
        .inst      (inst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    line_mem #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) u_line_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

//--- verif/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_en,
    input  addr_t pc,
    input  logic  stall,
    input  word_t inst,
    input  int    test_no,
    input  word_t ref_inst,
    output addr_t track_addr,
    output int    checks,
    output int    errors
);

    // model of the tag arrays and lru bits
    tag_t model_tag   [2][SETS];
    logic model_valid [2][SETS];
    logic model_lru   [SETS];

    logic        pending;
    logic        pend_miss;
    int          pend_test;
    int          stall_cycles;
    miss_state_t phase;

    function automatic string test_name(input int t);
        case (t)
            1:       return "cold_miss";
            2:       return "warm_hit";
            3:       return "line_offsets";
            4:       return "lru_evict";
            5:       return "random_stream";
            default: return "reset";
        endcase
    endfunction

    // returns 1 on a miss and updates the model
    function automatic logic model_access(input addr_t a);
        index_t idx;
        tag_t   tg;
        logic   hit;
        logic   way;
        idx = a[11:5];
        tg  = a[31:12];
        hit = 1'b1;
        if (model_valid[0][idx] && model_tag[0][idx] == tg) begin
            way = 1'b0;
        end else if (model_valid[1][idx] && model_tag[1][idx] == tg) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            way = model_lru[idx];
            model_tag[way][idx]   = tg;
            model_valid[way][idx] = 1'b1;
        end
        // the way just used is not the next victim
        model_lru[idx] = !way;
        return !hit;
    endfunction

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name(pend_test), what, exp, act);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                model_valid[0][s] = 1'b0;
                model_valid[1][s] = 1'b0;
                model_lru[s]      = 1'b0;
            end
            pending   = 1'b0;
            pend_test = 0;
            checks    = 0;
            errors    = 0;
        end else begin
            if (!pending) begin
                if (stall !== 1'b0) begin
                    fail_value("stall with no fetch outstanding", 32'd0, 32'(stall));
                end
            end else if (stall === 1'b1) begin
                stall_cycles++;
                phase = REQUEST;
            end else begin
                checks++;
                if (inst !== ref_inst) begin
                    fail_value($sformatf("inst at %h", track_addr), ref_inst, inst);
                end
                // a hit answers in the cycle after acceptance
                if (!pend_miss && stall_cycles != 0) begin
                    fail_value($sformatf("hit stall cycles in %s", phase.name()), 32'd0,
                               32'(stall_cycles));
                end
                if (pend_miss && stall_cycles == 0) begin
                    fail_value("miss stall seen", 32'd1, 32'd0);
                end
                pending = 1'b0;
            end
            // presented now, accepted at the next rising edge
            if (!pending && inst_en && stall === 1'b0) begin
                pending      = 1'b1;
                track_addr   = pc;
                pend_test    = test_no;
                pend_miss    = model_access(pc);
                stall_cycles = 0;
                phase        = LOOKUP;
            end
        end
    end

endmodule

//--- verif/tb_fetch_cache.sv
`timescale 1ns/1ps

module tb_fetch_cache
    import cache_pkg::*;
();

    localparam int MEM_LATENCY  = 4;
    localparam int MEM_LINES    = 1024;
    localparam int MEM_WORDS    = MEM_LINES * WORDS_PER_LINE;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 23;
    localparam int N_RANDOM     = 300;
    // worst case every fetch misses, plus reset and preload
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * (MEM_LATENCY + 4)
                                    + RESET_CYCLES + MEM_LINES + 32;

    logic  clk;
    logic  reset;
    logic  inst_en;
    addr_t pc;
    logic  stall;
    word_t inst;
    logic  load_en;
    addr_t load_addr;
    line_t load_data;

    int    test_no;
    addr_t track_addr;
    word_t ref_inst;
    int    checks;
    int    errors;
    int    seed;
    int    fetch_count;
    word_t r;

    // copy of the backing memory contents
    word_t mem_copy [MEM_WORDS];

    fetch_cache_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .inst_en   (inst_en),
        .pc        (pc),
        .stall     (stall),
        .inst      (inst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fetch_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .pc         (pc),
        .stall      (stall),
        .inst       (inst),
        .test_no    (test_no),
        .ref_inst   (ref_inst),
        .track_addr (track_addr),
        .checks     (checks),
        .errors     (errors)
    );

    function automatic word_t expected_inst(input addr_t a);
        return mem_copy[int'((a >> 2) % MEM_WORDS)];
    endfunction

    assign ref_inst = expected_inst(track_addr);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic preload_memory();
        line_t l;
        word_t w;
        for (int n = 0; n < MEM_LINES; n++) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                w = $random(seed);
                l[k*32 +: 32] = w;
                mem_copy[n*WORDS_PER_LINE + k] = w;
            end
            load_en   <= 1'b1;
            load_addr <= addr_t'(n);
            load_data <= l;
            @(posedge clk);
        end
        load_en <= 1'b0;
    endtask

    // pc and inst_en stay put until the fetch is accepted
    task automatic fetch(input addr_t a, input int t);
        pc      <= a;
        inst_en <= 1'b1;
        test_no <= t;
        fetch_count++;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_idle();
        inst_en <= 1'b0;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    initial begin
        reset       = 1'b1;
        inst_en     = 1'b0;
        pc          = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        test_no     = 0;
        seed        = 74;
        fetch_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        preload_memory();

        // cold lines in four different sets, then the same lines warm
        fetch(32'h0000_0000, 1);
        fetch(32'h0000_0044, 1);
        fetch(32'h0000_0108, 1);
        fetch(32'h0000_0a1c, 1);
        fetch(32'h0000_0004, 2);
        fetch(32'h0000_0040, 2);
        fetch(32'h0000_010c, 2);
        fetch(32'h0000_0a00, 2);
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            fetch(32'h0000_0100 + addr_t'(k * 4), 3);
        end

        // three tags in set 0x30
        fetch(32'h0000_1600, 4);
        fetch(32'h0000_2600, 4);
        fetch(32'h0000_1604, 4);
        fetch(32'h0000_2608, 4);
        fetch(32'h0000_3600, 4);
        fetch(32'h0000_260c, 4);
        fetch(32'h0000_1610, 4);

        // eight tags over sets 0 to 15
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            fetch(r & 32'h0000_71fc, 5);
        end
        wait_idle();
        repeat (2) @(posedge clk);

        if (checks != fetch_count) begin
            $display("checker saw %0d results for %0d fetches", checks, fetch_count);
        end
        $display("fetches %0d, checked %0d, errors %0d", fetch_count, checks, errors);
        if (errors == 0 && checks == fetch_count) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- fetch_cache.f
hw/cache_pkg.sv
hw/sdp_ram.sv
hw/icache.sv
hw/line_mem.sv
hw/fetch_cache_top.sv
verif/fetch_checker.sv
verif/tb_fetch_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f fetch_cache.f \
    --top-module tb_fetch_cache --Mdir obj_dir -o sim_fetch_cache
./obj_dir/sim_fetch_cache | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
